//--- common/apb_chk_defs.svh
////////////////////////////////////////////////////////////
// APB4 protocol checker global defines
// Bus field widths, watchdog limit and counter width
////////////////////////////////////////////////////////////

`ifndef APB_CHK_DEFS_SVH
`define APB_CHK_DEFS_SVH

// PADDR width in bits
`define APB_ADDR_W 32

// PWDATA width in bits
`define APB_DATA_W 32

// One strobe lane per data byte
`define APB_STRB_W 4

// PPROT width
`define APB_PROT_W 3

// Default number of open-transfer samples before the watchdog fires
// Zero turns the watchdog off
`define APB_WDOG_CYCLES 16

// Width of the saturating violation-cycle counter
`define APB_ERR_CNT_W 8

`endif

//--- common/apb_chk_if.sv
////////////////////////////////////////////////////////////
// APB bus sample interface
// Transfer phase interface shared by the rule checkers
////////////////////////////////////////////////////////////

interface apb_bus_if;
  import apb_chk_pkg::*;

  logic  psel;
  logic  penable;
  logic  pready;
  logic  pwrite;
  addr_t paddr;
  strb_t pstrb;
  prot_t pprot;
  data_t pwdata;

  // Checkers only observe the bus
  modport monitor (
    input psel, penable, pready, pwrite,
    input paddr, pstrb, pprot, pwdata
  );

endinterface

interface apb_phase_if;
  import apb_chk_pkg::*;

  phase_e phase;
  // First PSEL-high sample of a transfer
  logic   setup_phase;
  // PSEL-high sample after setup, transfer not yet completed
  logic   access_phase;
  // Previous sample was selected and did not complete
  logic   xfer_open;
  // PSEL, PENABLE and PREADY all high now
  logic   xfer_done;

  modport tracker (
    output phase, setup_phase, access_phase, xfer_open, xfer_done
  );

  modport observer (
    input phase, setup_phase, access_phase, xfer_open, xfer_done
  );

endinterface

//--- common/apb_chk_pkg.sv
////////////////////////////////////////////////////////////
// APB4 protocol checker package
// Bus vector types, transfer phase enum and rule bit positions
////////////////////////////////////////////////////////////

`include "apb_chk_defs.svh"

package apb_chk_pkg;

  // Bus field vectors
  typedef logic [`APB_ADDR_W-1:0] addr_t;
  typedef logic [`APB_DATA_W-1:0] data_t;
  typedef logic [`APB_STRB_W-1:0] strb_t;
  typedef logic [`APB_PROT_W-1:0] prot_t;

  // Phase of the sampled bus cycle
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_SETUP,
    PH_ACCESS
  } phase_e;

  // Bit positions in the violation vector, one per rule
  typedef enum logic [3:0] {
    ERR_PSEL_DROP,
    ERR_EN_IN_SETUP,
    ERR_EN_MISSING,
    ERR_ADDR_UNSTABLE,
    ERR_WRITE_UNSTABLE,
    ERR_STRB_UNSTABLE,
    ERR_PROT_UNSTABLE,
    ERR_WDATA_UNSTABLE,
    ERR_STRB_PATTERN,
    ERR_STRB_ON_READ,
    ERR_STRB_MISALIGN,
    ERR_ADDR_UNALIGNED,
    ERR_WATCHDOG
  } err_bit_e;

  // Vector width follows the last rule bit
  localparam int ERR_W = int'(ERR_WATCHDOG) + 1;

  typedef logic [ERR_W-1:0] err_vec_t;

  // Saturating count of cycles with any violation
  typedef logic [`APB_ERR_CNT_W-1:0] err_cnt_t;

endpackage

//--- design/apb_checker_top.sv
////////////////////////////////////////////////////////////
// APB4 protocol checker top level
// Plain APB ports, bus and phase interfaces, rule checkers
////////////////////////////////////////////////////////////

`include "apb_chk_defs.svh"

module apb_checker_top (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  logic                  PSEL,
  input  logic                  PENABLE,
  input  logic                  PREADY,
  input  logic                  PWRITE,
  input  apb_chk_pkg::addr_t    PADDR,
  input  apb_chk_pkg::strb_t    PSTRB,
  input  apb_chk_pkg::prot_t    PPROT,
  input  apb_chk_pkg::data_t    PWDATA,
  output apb_chk_pkg::err_vec_t err_flags,
  output apb_chk_pkg::err_cnt_t err_count,
  output logic                  err_any
);
  import apb_chk_pkg::*;

  // Per-checker violation vectors
  err_vec_t err_stab;
  err_vec_t err_strb;
  err_vec_t err_wdog;

  apb_bus_if   bus ();
  apb_phase_if phs ();

  // Sampled APB signals
  assign bus.psel    = PSEL;
  assign bus.penable = PENABLE;
  assign bus.pready  = PREADY;
  assign bus.pwrite  = PWRITE;
  assign bus.paddr   = PADDR;
  assign bus.pstrb   = PSTRB;
  assign bus.pprot   = PPROT;
  assign bus.pwdata  = PWDATA;

  apb_phase_tracker u_phase (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .bus     (bus),
    .phase   (phs)
  );

  apb_stability_checker u_stab (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .bus     (bus),
    .phase   (phs),
    .err     (err_stab)
  );

  apb_strobe_checker u_strb (
    .bus     (bus),
    .phase   (phs),
    .err     (err_strb)
  );

  apb_watchdog #(
    .TIMEOUT (`APB_WDOG_CYCLES)
  ) u_wdog (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .phase   (phs),
    .err     (err_wdog)
  );

  apb_error_collector u_coll (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .err_stab  (err_stab),
    .err_strb  (err_strb),
    .err_wdog  (err_wdog),
    .err_flags (err_flags),
    .err_count (err_count),
    .err_any   (err_any)
  );

endmodule

//--- design/apb_error_collector.sv
////////////////////////////////////////////////////////////
// Violation collector
// Sticky flags, saturating cycle count and any-error level
////////////////////////////////////////////////////////////

module apb_error_collector (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  apb_chk_pkg::err_vec_t err_stab,
  input  apb_chk_pkg::err_vec_t err_strb,
  input  apb_chk_pkg::err_vec_t err_wdog,
  output apb_chk_pkg::err_vec_t err_flags,
  output apb_chk_pkg::err_cnt_t err_count,
  output logic                  err_any
);
  import apb_chk_pkg::*;

  // New violations of this sample
  err_vec_t err_now;
  logic     hit;

  // Checkers own disjoint bits
  assign err_now = err_stab | err_strb | err_wdog;
  assign hit     = |err_now;

  ////////////////////////////////////////////////////////////
  // Sticky flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      err_flags <= '0;
    else
      err_flags <= err_flags | err_now;
  end

  ////////////////////////////////////////////////////////////
  // Violation cycle counter that stops at all ones
  ////////////////////////////////////////////////////////////
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      err_count <= '0;
    else if (hit && err_count != '1)
      err_count <= err_count + 1'b1;
  end

  // Level follows the sticky flags
  assign err_any = |err_flags;

endmodule

//--- design/apb_phase_tracker.sv
////////////////////////////////////////////////////////////
// APB transfer phase FSM
// Produces setup/access flags and transfer open/done status
////////////////////////////////////////////////////////////

module apb_phase_tracker (
  input logic            PCLK,
  input logic            PRESETn,
  apb_bus_if.monitor     bus,
  apb_phase_if.tracker   phase
);
  import apb_chk_pkg::*;

  // Phase of the previous sample
  phase_e state;
  // Phase of the current sample
  phase_e cur_phase;
  // Previous sample completed its transfer
  logic   prev_done;
  // Previous sample had PSEL high
  logic   prev_psel;
  logic   done_now;

  assign done_now  = bus.psel & bus.penable & bus.pready;
  assign prev_psel = (state != PH_IDLE);

  ////////////////////////////////////////////////////////////
  // Next phase from the registered phase and current sample
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    case (state)
      PH_IDLE:
        cur_phase = bus.psel ? PH_SETUP : PH_IDLE;
      default:
      begin
        if (!bus.psel)
          cur_phase = PH_IDLE;
        // Back-to-back transfer with PSEL held high
        else if (prev_done)
          cur_phase = PH_SETUP;
        else
          cur_phase = PH_ACCESS;
      end
    endcase
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      state     <= PH_IDLE;
      prev_done <= 1'b0;
    end
    else
    begin
      state     <= cur_phase;
      prev_done <= done_now;
    end
  end

  // Status seen by the rule checkers
  assign phase.phase        = cur_phase;
  assign phase.setup_phase  = (cur_phase == PH_SETUP);
  assign phase.access_phase = (cur_phase == PH_ACCESS);
  assign phase.xfer_open    = prev_psel & ~prev_done;
  assign phase.xfer_done    = done_now;

endmodule

//--- design/apb_stability_checker.sv
////////////////////////////////////////////////////////////
// PSEL and PENABLE sequencing rules
// Request field stability across an open transfer
////////////////////////////////////////////////////////////

module apb_stability_checker (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  apb_bus_if.monitor            bus,
  apb_phase_if.observer         phase,
  output apb_chk_pkg::err_vec_t err
);
  import apb_chk_pkg::*;

  // Request fields of the previous sample
  addr_t prev_paddr;
  logic  prev_pwrite;
  strb_t prev_pstrb;
  prot_t prev_pprot;
  data_t prev_pwdata;

  // Selected and still inside the same transfer
  logic  hold;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      prev_paddr  <= '0;
      prev_pwrite <= 1'b0;
      prev_pstrb  <= '0;
      prev_pprot  <= '0;
      prev_pwdata <= '0;
    end
    else
    begin
      prev_paddr  <= bus.paddr;
      prev_pwrite <= bus.pwrite;
      prev_pstrb  <= bus.pstrb;
      prev_pprot  <= bus.pprot;
      prev_pwdata <= bus.pwdata;
    end
  end

  assign hold = bus.psel & phase.xfer_open;

  ////////////////////////////////////////////////////////////
  // Rule evaluation
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    err = '0;

    // PSEL released before PREADY ended the access
    err[ERR_PSEL_DROP]   = ~bus.psel & phase.xfer_open;
    // PENABLE must be low in the first cycle
    err[ERR_EN_IN_SETUP] = phase.setup_phase & bus.penable;
    // PENABLE must stay high through the access
    err[ERR_EN_MISSING]  = phase.access_phase & ~bus.penable;

    // Fields frozen while the transfer is open
    err[ERR_ADDR_UNSTABLE]  = hold & (bus.paddr != prev_paddr);
    err[ERR_WRITE_UNSTABLE] = hold & (bus.pwrite != prev_pwrite);
    err[ERR_STRB_UNSTABLE]  = hold & (bus.pstrb != prev_pstrb);
    err[ERR_PROT_UNSTABLE]  = hold & (bus.pprot != prev_pprot);
    // Write data only matters on writes
    err[ERR_WDATA_UNSTABLE] = hold & bus.pwrite & (bus.pwdata != prev_pwdata);
  end

endmodule

//--- design/apb_strobe_checker.sv
////////////////////////////////////////////////////////////
// PSTRB pattern, read strobe and strobe alignment rules
// PADDR word alignment rule
////////////////////////////////////////////////////////////

`include "apb_chk_defs.svh"

module apb_strobe_checker (
  apb_bus_if.monitor            bus,
  apb_phase_if.observer         phase,
  output apb_chk_pkg::err_vec_t err
);
  import apb_chk_pkg::*;

  localparam int STRB_W  = `APB_STRB_W;
  // Address bits covered by one data word
  localparam int LANE_LG = $clog2(STRB_W);
  localparam int LG_W    = $clog2(LANE_LG + 1);

  // PSEL high in either phase
  logic                in_xfer;
  // Strobe is a naturally aligned group of 2^n lanes
  logic                strb_ok;
  // n of the matching group
  logic [LG_W-1:0]     strb_lg;
  // Address bits that must be zero for that group size
  logic [LANE_LG-1:0]  lane_mask;

  assign in_xfer = phase.setup_phase | phase.access_phase;

  ////////////////////////////////////////////////////////////
  // Match the strobe against every legal lane group
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    strb_ok = 1'b0;
    strb_lg = '0;
    for (int lg = 0; lg <= LANE_LG; lg++)
    begin
      for (int grp = 0; grp < (STRB_W >> lg); grp++)
      begin
        // Group of 2^lg ones starting at lane grp*2^lg
        if (bus.pstrb == strb_t'(((1 << (1 << lg)) - 1) << (grp << lg)))
        begin
          strb_ok = 1'b1;
          strb_lg = LG_W'(lg);
        end
      end
    end
  end

  assign lane_mask = LANE_LG'((1 << strb_lg) - 1);

  always_comb
  begin
    err = '0;

    // Nonzero strobe outside byte/halfword/word groups
    err[ERR_STRB_PATTERN]   = in_xfer & (|bus.pstrb) & ~strb_ok;
    // Reads carry no strobes
    err[ERR_STRB_ON_READ]   = in_xfer & ~bus.pwrite & (|bus.pstrb);
    // Address offset must match the strobe group size
    err[ERR_STRB_MISALIGN]  = in_xfer & bus.pwrite & strb_ok &
                              (|(bus.paddr[LANE_LG-1:0] & lane_mask));
    // Word-aligned addresses only
    err[ERR_ADDR_UNALIGNED] = in_xfer & (|bus.paddr[LANE_LG-1:0]);
  end

endmodule

//--- design/apb_watchdog.sv
////////////////////////////////////////////////////////////
// Transfer watchdog
// Flags a transfer that stays open for TIMEOUT samples
////////////////////////////////////////////////////////////

`include "apb_chk_defs.svh"

module apb_watchdog #(
  parameter int TIMEOUT = `APB_WDOG_CYCLES
) (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  apb_phase_if.observer         phase,
  output apb_chk_pkg::err_vec_t err
);
  import apb_chk_pkg::*;

  localparam int CNT_W = (TIMEOUT > 0) ? $clog2(TIMEOUT + 1) : 1;

  // Earlier consecutive open samples up to TIMEOUT
  logic [CNT_W-1:0] cnt;
  // Open transfer with PSEL still high and no completion yet
  logic             running;
  logic             hit;

  assign running = phase.xfer_open & (phase.phase == PH_ACCESS) & ~phase.xfer_done;
  // This sample makes the count reach TIMEOUT
  assign hit     = (TIMEOUT > 0) & running & (int'(cnt) == TIMEOUT - 1);

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      cnt <= '0;
    else if (!running || TIMEOUT == 0)
      cnt <= '0;
    // Hold once reached so the flag fires a single time
    else if (int'(cnt) != TIMEOUT)
      cnt <= cnt + 1'b1;
  end

  always_comb
  begin
    err = '0;
    err[ERR_WATCHDOG] = hit;
  end

endmodule

//--- tb.f
+incdir+common
common/apb_chk_pkg.sv
common/apb_chk_if.sv
design/apb_phase_tracker.sv
design/apb_stability_checker.sv
design/apb_strobe_checker.sv
design/apb_watchdog.sv
design/apb_error_collector.sv
design/apb_checker_top.sv
verification/apb_checker_tb.sv

//--- verification/apb_checker_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the APB4 protocol checker
// Clock, reset, per-cycle stimulus table, expected flags,
// count and level, compare tasks and cycle timeout
////////////////////////////////////////////////////////////

`include "apb_chk_defs.svh"

module apb_checker_tb;
  import apb_chk_pkg::*;

  // Word-aligned base address for all transfers
  localparam addr_t BASE = 32'h0000_1000;

  logic     PCLK;
  logic     PRESETn;
  logic     psel;
  logic     penable;
  logic     pready;
  logic     pwrite;
  addr_t    paddr;
  strb_t    pstrb;
  prot_t    pprot;
  data_t    pwdata;
  err_vec_t err_flags;
  err_cnt_t err_count;
  logic     err_any;

  // Stimulus table with one entry per sampled cycle
  logic     row_rst[$];
  logic     row_sel[$];
  logic     row_en[$];
  logic     row_rdy[$];
  logic     row_wr[$];
  addr_t    row_addr[$];
  strb_t    row_strb[$];
  prot_t    row_prot[$];
  data_t    row_wdata[$];
  err_vec_t row_exp[$];

  // Reference model state
  err_vec_t exp_flags;
  err_cnt_t exp_count;
  int       cur_row;
  int       cycles = 0;
  int       limit = 0;

  apb_checker_top UUT (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .PSEL      (psel),
    .PENABLE   (penable),
    .PREADY    (pready),
    .PWRITE    (pwrite),
    .PADDR     (paddr),
    .PSTRB     (pstrb),
    .PPROT     (pprot),
    .PWDATA    (pwdata),
    .err_flags (err_flags),
    .err_count (err_count),
    .err_any   (err_any)
  );

  always #5 PCLK = ~PCLK;

  // Cycle budget guard
  always @(posedge PCLK)
  begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // One-hot vector for a rule position
  function automatic err_vec_t rule_bit(input err_bit_e b);
    err_vec_t v;
    v    = '0;
    v[b] = 1'b1;
    return v;
  endfunction

  task automatic add_row(input logic rst, input logic sel, input logic en,
                         input logic rdy, input logic wr, input addr_t addr,
                         input strb_t strb, input prot_t prot, input data_t wdata,
                         input err_vec_t exp);
    row_rst.push_back(rst);
    row_sel.push_back(sel);
    row_en.push_back(en);
    row_rdy.push_back(rdy);
    row_wr.push_back(wr);
    row_addr.push_back(addr);
    row_strb.push_back(strb);
    row_prot.push_back(prot);
    row_wdata.push_back(wdata);
    row_exp.push_back(exp);
  endtask

  // Bus parked with PSEL low
  task automatic idle_row(input logic rst, input err_vec_t exp);
    add_row(rst, 0, 0, 0, 0, '0, '0, '0, '0, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // Table contents
  ////////////////////////////////////////////////////////////
  task automatic build_table();
    data_t    wd;
    err_vec_t wexp;
    wd = $urandom;
    // Legal zero-wait write and stalled read
    add_row(0, 1, 0, 0, 1, BASE, 4'hF, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 1, BASE, 4'hF, 3'h0, wd, '0);
    idle_row(0, '0);
    add_row(0, 1, 0, 0, 0, BASE + 4, 4'h0, 3'h2, wd, '0);
    add_row(0, 1, 1, 0, 0, BASE + 4, 4'h0, 3'h2, wd, '0);
    // Write data may move during a read access
    add_row(0, 1, 1, 0, 0, BASE + 4, 4'h0, 3'h2, ~wd, '0);
    add_row(0, 1, 1, 1, 0, BASE + 4, 4'h0, 3'h2, ~wd, '0);
    // Legal back-to-back halfword and byte transfers with PSEL held
    add_row(0, 1, 0, 0, 1, BASE + 8, 4'h3, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 1, BASE + 8, 4'h3, 3'h0, wd, '0);
    add_row(0, 1, 0, 0, 1, BASE + 8, 4'hC, 3'h0, ~wd, '0);
    add_row(0, 1, 1, 1, 1, BASE + 8, 4'hC, 3'h0, ~wd, '0);
    add_row(0, 1, 0, 0, 1, BASE + 12, 4'h1, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 1, BASE + 12, 4'h1, 3'h0, wd, '0);
    add_row(0, 1, 0, 0, 1, BASE + 12, 4'h8, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 1, BASE + 12, 4'h8, 3'h0, wd, '0);
    // Stray strobe and address bits are ignored while PSEL is low
    add_row(0, 0, 0, 0, 0, BASE + 1, 4'h6, 3'h0, wd, '0);
    // Sequencing errors for PENABLE in setup, PENABLE missing and PSEL drop
    add_row(0, 1, 1, 0, 0, BASE, 4'h0, 3'h0, wd, rule_bit(ERR_EN_IN_SETUP));
    add_row(0, 1, 1, 1, 0, BASE, 4'h0, 3'h0, wd, '0);
    idle_row(0, '0);
    add_row(0, 1, 0, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    add_row(0, 1, 0, 1, 0, BASE, 4'h0, 3'h0, wd, rule_bit(ERR_EN_MISSING));
    add_row(0, 1, 1, 1, 0, BASE, 4'h0, 3'h0, wd, '0);
    idle_row(0, '0);
    add_row(0, 1, 0, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    add_row(0, 1, 1, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    idle_row(0, rule_bit(ERR_PSEL_DROP));
    idle_row(0, '0);
    // One field changed per stalled access
    add_row(0, 1, 0, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    add_row(0, 1, 1, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 0, BASE + 16, 4'h0, 3'h0, wd, rule_bit(ERR_ADDR_UNSTABLE));
    add_row(0, 1, 0, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    add_row(0, 1, 1, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 1, BASE, 4'h0, 3'h0, wd, rule_bit(ERR_WRITE_UNSTABLE));
    add_row(0, 1, 0, 0, 1, BASE, 4'hF, 3'h0, wd, '0);
    add_row(0, 1, 1, 0, 1, BASE, 4'hF, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 1, BASE, 4'h3, 3'h0, wd, rule_bit(ERR_STRB_UNSTABLE));
    add_row(0, 1, 0, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    add_row(0, 1, 1, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 0, BASE, 4'h0, 3'h5, wd, rule_bit(ERR_PROT_UNSTABLE));
    add_row(0, 1, 0, 0, 1, BASE, 4'hF, 3'h0, wd, '0);
    add_row(0, 1, 1, 0, 1, BASE, 4'hF, 3'h0, wd, '0);
    add_row(0, 1, 1, 1, 1, BASE, 4'hF, 3'h0, ~wd, rule_bit(ERR_WDATA_UNSTABLE));
    idle_row(0, '0);
    // Strobe and address rules flag in setup and access alike
    add_row(0, 1, 0, 0, 1, BASE, 4'h6, 3'h0, wd, rule_bit(ERR_STRB_PATTERN));
    add_row(0, 1, 1, 1, 1, BASE, 4'h6, 3'h0, wd, rule_bit(ERR_STRB_PATTERN));
    add_row(0, 1, 0, 0, 0, BASE, 4'h1, 3'h0, wd, rule_bit(ERR_STRB_ON_READ));
    add_row(0, 1, 1, 1, 0, BASE, 4'h1, 3'h0, wd, rule_bit(ERR_STRB_ON_READ));
    wexp = rule_bit(ERR_STRB_MISALIGN) | rule_bit(ERR_ADDR_UNALIGNED);
    add_row(0, 1, 0, 0, 1, BASE + 1, 4'h3, 3'h0, wd, wexp);
    add_row(0, 1, 1, 1, 1, BASE + 1, 4'h3, 3'h0, wd, wexp);
    add_row(0, 1, 0, 0, 0, BASE + 2, 4'h0, 3'h0, wd, rule_bit(ERR_ADDR_UNALIGNED));
    add_row(0, 1, 1, 1, 0, BASE + 2, 4'h0, 3'h0, wd, rule_bit(ERR_ADDR_UNALIGNED));
    idle_row(0, '0);
    // Watchdog fires once on the open sample that reaches the limit
    add_row(0, 1, 0, 0, 0, BASE, 4'h0, 3'h0, wd, '0);
    for (int k = 1; k <= `APB_WDOG_CYCLES + 4; k++)
    begin
      wexp = (k == `APB_WDOG_CYCLES) ? rule_bit(ERR_WATCHDOG) : '0;
      add_row(0, 1, 1, 0, 0, BASE, 4'h0, 3'h0, wd, wexp);
    end
    add_row(0, 1, 1, 1, 0, BASE, 4'h0, 3'h0, wd, '0);
    idle_row(0, '0);
    // Reset clears everything before a clean write
    idle_row(1, '0);
    add_row(0, 1, 0, 0, 1, BASE, 4'hF, 3'h1, wd, '0);
    add_row(0, 1, 1, 1, 1, BASE, 4'hF, 3'h1, wd, '0);
    idle_row(0, '0);
  endtask

  task automatic drive_idle();
    psel    = 1'b0;
    penable = 1'b0;
    pready  = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pstrb   = '0;
    pprot   = '0;
    pwdata  = '0;
  endtask

  task automatic drive_row(input int i);
    psel    = row_sel[i];
    penable = row_en[i];
    pready  = row_rdy[i];
    pwrite  = row_wr[i];
    paddr   = row_addr[i];
    pstrb   = row_strb[i];
    pprot   = row_prot[i];
    pwdata  = row_wdata[i];
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks for each output kind
  ////////////////////////////////////////////////////////////
  task automatic expect_flags(input err_vec_t exp, input err_vec_t act);
    if (act !== exp)
    begin
      $display("Error: err_flags row %0d expected 0x%h actual 0x%h", cur_row, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(input err_cnt_t exp, input err_cnt_t act);
    if (act !== exp)
    begin
      $display("Error: err_count row %0d expected 0x%h actual 0x%h", cur_row, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic verify_any(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Error: err_any row %0d expected 0x%h actual 0x%h", cur_row, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic compare_outputs();
    expect_flags(exp_flags, err_flags);
    check_count(exp_count, err_count);
    verify_any(|exp_flags, err_any);
  endtask

  initial
  begin
    void'($urandom(32'h3734_3fc5));
    PCLK      = 1'b0;
    PRESETn   = 1'b0;
    drive_idle();
    exp_flags = '0;
    exp_count = '0;
    cur_row   = -1;
    build_table();
    limit = row_sel.size() + `APB_WDOG_CYCLES + 50;
    repeat (3) @(negedge PCLK);
    PRESETn = 1'b1;
    compare_outputs();
    for (int i = 0; i < row_sel.size(); i++)
    begin
      cur_row = i;
      // Async reset held for one full cycle clears all outputs
      if (row_rst[i])
      begin
        PRESETn = 1'b0;
        drive_idle();
        @(negedge PCLK);
        exp_flags = '0;
        exp_count = '0;
        compare_outputs();
        PRESETn = 1'b1;
      end
      drive_row(i);
      @(posedge PCLK);
      @(negedge PCLK);
      // Sticky OR and saturating count of violating cycles
      exp_flags = exp_flags | row_exp[i];
      if (row_exp[i] != '0 && exp_count != '1)
        exp_count = exp_count + 1'b1;
      compare_outputs();
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
